// File: src/msx_loader_pkg.sv
`default_nettype none

package msx_loader_pkg;

   localparam int DDR_ADDR_W = 28;
   localparam int RAM_ADDR_W = 27;
   localparam int KBD_SKIP   = 512;                   // Keyboard layout block

   typedef enum logic [3:0] {
      CONFIG_CONFIG        = 4'd0,
      CONFIG_KBD_LAYOUT    = 4'd1,
      CONFIG_SLOT_INTERNAL = 4'd2
   } config_typ_t;

   typedef enum logic [7:0] {
      DATA_NONE = 8'd0,
      DATA_ROM  = 8'd1,
      DATA_RAM  = 8'd2
   } data_id_t;

   typedef logic [7:0] mapper_t;
   typedef logic [7:0] device_t;

   localparam mapper_t MAPPER_UNUSED = 8'd0;
   localparam device_t DEVICE_NONE   = 8'd0;

   typedef struct packed {
      mapper_t    mapper;
      device_t    device;
      logic [3:0] ref_ram;                            // Index into lookup table
      logic [1:0] offset_ram;                         // Page offset within the region
   } slot_entry_t;

   typedef struct packed {
      logic [RAM_ADDR_W-1:0] addr;
      logic [15:0]           size;                    // In pages
      logic                  ro;
   } lookup_t;

   typedef struct packed {
      logic [3:0] slot_expander_en;
      logic [1:0] msx_type;
   } bios_config_t;

   typedef struct packed {
      logic [3:0]  slot_subslot;
      data_id_t    data_id;
      logic [10:0] pages;
      device_t     device;
      mapper_t     mapper;
      logic [7:0]  mode;                              // 2 bits per block
      logic [7:0]  param;                             // 2 bits per block
   } record_t;

   typedef enum logic [1:0] {
      OP_HEADER,
      OP_COPY,
      OP_FILL
   } mover_op_t;

   typedef struct packed {
      logic                  cyc;
      logic                  stb;
      logic                  we;
      logic [DDR_ADDR_W-1:0] adr;
      logic [7:0]            dat;
   } wb_ddr_m_t;

   typedef struct packed {
      logic                  cyc;
      logic                  stb;
      logic                  we;
      logic [RAM_ADDR_W-1:0] adr;
      logic [7:0]            dat;
   } wb_ram_m_t;

   typedef struct packed {
      logic       ack;
      logic [7:0] dat;
   } wb_s_t;

endpackage

`default_nettype wire

// File: src/wb_master.sv
`default_nettype none

module wb_master #(
   parameter type BUS_T = msx_loader_pkg::wb_ddr_m_t
) (
   input  wire logic                  clk,
   input  wire logic                  reset,
   input  wire logic                  start,
   input  wire logic                  we,
   input  wire logic [27:0]           adr,
   input  wire logic [7:0]            wdat,
   input  wire msx_loader_pkg::wb_s_t s,
   output BUS_T                       m,
   output logic                       done,
   output logic [7:0]                 rdat
);

   // Bus address width is what remains after cyc, stb, we and 8 data bits
   localparam int AW = $bits(BUS_T) - 11;

   always_ff @(posedge clk) begin
      done <= 1'b0;
      if (start) begin
         m.cyc <= 1'b1;
         m.stb <= 1'b1;
         m.we  <= we;
         m.adr <= adr[AW-1:0];
         m.dat <= wdat;
      end
      if (m.cyc && s.ack) begin                       // Drop bus after ack
         m.cyc <= 1'b0;
         m.stb <= 1'b0;
         done  <= 1'b1;
         rdat  <= s.dat;
      end
      if (reset) begin
         m.cyc <= 1'b0;
         m.stb <= 1'b0;
         done  <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: src/byte_mover.sv
`default_nettype none

module byte_mover (
   input  wire logic                      clk,
   input  wire logic                      reset,
   input  wire logic                      go,
   input  wire msx_loader_pkg::mover_op_t op,
   input  wire logic [27:0]               ddr_start,
   input  wire logic [26:0]               ram_start,
   input  wire logic [27:0]               count,
   input  wire msx_loader_pkg::wb_s_t     ddr_s,
   input  wire msx_loader_pkg::wb_s_t     ram_s,
   output logic                           hdr_valid,
   output logic [7:0]                     hdr_byte,
   output logic                           done,
   output logic [27:0]                    next_ddr,
   output msx_loader_pkg::wb_ddr_m_t      ddr_m,
   output msx_loader_pkg::wb_ram_m_t      ram_m
);

   typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_READ, S_WRITE} state_t;

   state_t                    state;
   msx_loader_pkg::mover_op_t op_r;
   logic [27:0]               ddr_adr;
   logic [26:0]               ram_adr;
   logic [27:0]               remain;
   logic                      ddr_go;
   logic                      ram_go;
   logic                      ddr_done;
   logic                      ram_done;
   logic [7:0]                ddr_rdat;
   logic [7:0]                ram_wdat;
   logic [7:0]                pattern;

   assign pattern   = (ram_adr[8] == ram_adr[1]) ? 8'hff : 8'h00;  // Power-on RAM pattern
   assign ram_wdat  = (op_r == msx_loader_pkg::OP_FILL) ? pattern : ddr_rdat;
   assign ddr_go    = state == S_ISSUE && remain != '0 && op_r != msx_loader_pkg::OP_FILL;
   assign ram_go    = (state == S_ISSUE && remain != '0 && op_r == msx_loader_pkg::OP_FILL) ||
                      (state == S_READ && ddr_done && op_r == msx_loader_pkg::OP_COPY);
   assign hdr_valid = ddr_done && op_r == msx_loader_pkg::OP_HEADER;
   assign hdr_byte  = ddr_rdat;
   assign next_ddr  = ddr_adr;

   always_ff @(posedge clk) begin
      done <= 1'b0;
      case (state)
         S_IDLE: begin
            if (go) begin
               op_r    <= op;
               ddr_adr <= ddr_start;
               ram_adr <= ram_start;
               remain  <= count;
               state   <= S_ISSUE;
            end
         end
         S_ISSUE: begin
            if (remain == '0) begin
               done  <= 1'b1;
               state <= S_IDLE;
            end else begin
               state <= (op_r == msx_loader_pkg::OP_FILL) ? S_WRITE : S_READ;
            end
         end
         S_READ: begin
            if (ddr_done) begin
               ddr_adr <= ddr_adr + 28'd1;
               if (op_r == msx_loader_pkg::OP_COPY) begin
                  state <= S_WRITE;                   // Write started this cycle
               end else begin
                  remain <= remain - 28'd1;
                  state  <= S_ISSUE;
               end
            end
         end
         S_WRITE: begin
            if (ram_done) begin
               ram_adr <= ram_adr + 27'd1;
               remain  <= remain - 28'd1;
               state   <= S_ISSUE;
            end
         end
         default: state <= S_IDLE;
      endcase
      if (reset) begin
         state <= S_IDLE;
         done  <= 1'b0;
      end
   end

   wb_master #(.BUS_T(msx_loader_pkg::wb_ddr_m_t)) u_ddr (
      .clk   (clk),
      .reset (reset),
      .start (ddr_go),
      .we    (1'b0),
      .adr   (ddr_adr),
      .wdat  (8'd0),
      .s     (ddr_s),
      .m     (ddr_m),
      .done  (ddr_done),
      .rdat  (ddr_rdat)
   );

   wb_master #(.BUS_T(msx_loader_pkg::wb_ram_m_t)) u_ram (
      .clk   (clk),
      .reset (reset),
      .start (ram_go),
      .we    (1'b1),
      .adr   ({1'b0, ram_adr}),
      .wdat  (ram_wdat),
      .s     (ram_s),
      .m     (ram_m),
      .done  (ram_done),
      .rdat  ()
   );

endmodule

`default_nettype wire

// File: src/slot_map.sv
`default_nettype none

module slot_map (
   input  wire logic                    clk,
   input  wire logic                    reset,
   input  wire logic                    clean,
   input  wire logic                    apply,
   input  wire msx_loader_pkg::record_t record,
   input  wire logic [3:0]              ref_ram,
   input  wire logic                    add_lookup,
   input  wire msx_loader_pkg::lookup_t lookup,
   input  wire logic [5:0]              slot_idx,
   input  wire logic [3:0]              lookup_idx,
   output logic                         clean_done,
   output msx_loader_pkg::slot_entry_t  slot_entry,
   output msx_loader_pkg::lookup_t      lookup_entry
);

   msx_loader_pkg::slot_entry_t slot_mem [64];
   msx_loader_pkg::lookup_t     lookup_mem [16];
   logic                        clean_busy;
   logic [5:0]                  clean_idx;

   assign slot_entry   = slot_mem[slot_idx];
   assign lookup_entry = lookup_mem[lookup_idx];

   always_ff @(posedge clk) begin
      clean_done <= 1'b0;
      if (clean) begin
         clean_busy <= 1'b1;
         clean_idx  <= 6'd0;
      end else if (clean_busy) begin
         clean_idx <= clean_idx + 6'd1;
         if (clean_idx == 6'd63) begin
            clean_busy <= 1'b0;
            clean_done <= 1'b1;
         end
      end
      if (reset) begin
         clean_busy <= 1'b0;
         clean_done <= 1'b0;
      end
   end

   // Mode 1 sources read the old table, the new values land together
   always_ff @(posedge clk) begin
      if (clean_busy) begin
         slot_mem[clean_idx] <= '{mapper: msx_loader_pkg::MAPPER_UNUSED,
                                  device: msx_loader_pkg::DEVICE_NONE,
                                  ref_ram: 4'd0, offset_ram: 2'd0};
      end
      if (apply) begin
         for (int b = 0; b < 4; b++) begin
            case (record.mode[2*b +: 2])
               2'd1: slot_mem[{record.slot_subslot, 2'(b)}] <= '{
                  mapper:     slot_mem[{record.slot_subslot, record.param[2*b +: 2]}].mapper,
                  device:     msx_loader_pkg::DEVICE_NONE,
                  ref_ram:    slot_mem[{record.slot_subslot, record.param[2*b +: 2]}].ref_ram,
                  offset_ram: slot_mem[{record.slot_subslot, record.param[2*b +: 2]}].offset_ram};
               2'd2: slot_mem[{record.slot_subslot, 2'(b)}] <= '{
                  mapper: record.mapper, device: record.device,
                  ref_ram: ref_ram, offset_ram: record.param[2*b +: 2]};
               2'd3: slot_mem[{record.slot_subslot, 2'(b)}] <= '{
                  mapper: msx_loader_pkg::MAPPER_UNUSED, device: record.device,
                  ref_ram: ref_ram, offset_ram: record.param[2*b +: 2]};
               default: ;                             // Keep entry
            endcase
         end
      end
      if (add_lookup) begin
         lookup_mem[ref_ram] <= lookup;
      end
   end

endmodule

`default_nettype wire

// File: src/config_sequencer.sv
`default_nettype none

module config_sequencer #(
   parameter int PAGE_BITS = 14
) (
   input  wire logic                       clk,
   input  wire logic                       reset,
   input  wire logic                       ioctl_download,
   input  wire logic [15:0]                ioctl_index,
   input  wire logic [26:0]                ioctl_addr,
   input  wire logic                       hdr_valid,
   input  wire logic [7:0]                 hdr_byte,
   input  wire logic                       done,
   input  wire logic [27:0]                next_ddr,
   input  wire logic                       clean_done,
   output logic                            go,
   output msx_loader_pkg::mover_op_t       op,
   output logic [27:0]                     ddr_start,
   output logic [26:0]                     ram_start,
   output logic [27:0]                     count,
   output logic                            clean,
   output logic                            apply,
   output msx_loader_pkg::record_t         record,
   output logic [3:0]                      ref_ram,
   output logic                            add_lookup,
   output msx_loader_pkg::lookup_t         lookup,
   output logic                            reset_rq,
   output msx_loader_pkg::bios_config_t    bios_config
);

   localparam int AW = msx_loader_pkg::DDR_ADDR_W;

   typedef enum logic [2:0] {
      S_IDLE, S_CLEAN, S_READ, S_READ_WAIT, S_CHECK, S_FILL, S_FILL_WAIT, S_STORE
   } state_t;

   state_t      state;
   logic        dl_last;
   logic [27:0] image_size;
   logic [27:0] ddr_adr;
   logic [26:0] ram_adr;
   logic [7:0]  conf [16];
   logic [3:0]  hdr_cnt;
   logic        inc_ref;
   logic [27:0] fill_bytes;

   assign reset_rq   = state != S_IDLE;
   assign fill_bytes = AW'(record.pages) << PAGE_BITS;

   always_ff @(posedge clk) begin
      go         <= 1'b0;
      clean      <= 1'b0;
      apply      <= 1'b0;
      add_lookup <= 1'b0;
      dl_last    <= ioctl_download;
      case (state)
         S_CLEAN: if (clean_done) state <= S_READ;
         S_READ: begin
            ref_ram <= ref_ram + {3'd0, inc_ref};     // After the previous apply
            inc_ref <= 1'b0;
            if (ddr_adr >= image_size) begin
               state <= S_IDLE;
            end else begin
               go        <= 1'b1;
               op        <= msx_loader_pkg::OP_HEADER;
               ddr_start <= ddr_adr;
               count     <= 28'd16;
               hdr_cnt   <= 4'd0;
               state     <= S_READ_WAIT;
            end
         end
         S_READ_WAIT: begin
            if (hdr_valid) begin
               conf[hdr_cnt] <= hdr_byte;
               hdr_cnt       <= hdr_cnt + 4'd1;
            end
            if (done) begin
               ddr_adr <= next_ddr;
               state   <= S_CHECK;
            end
         end
         S_CHECK: begin
            state <= S_READ;
            if ({conf[0], conf[1], conf[2]} != "MSX") begin
               state <= S_IDLE;                       // End of chain
            end else begin
               case (msx_loader_pkg::config_typ_t'(conf[3][7:4]))
                  msx_loader_pkg::CONFIG_CONFIG:
                     bios_config <= '{slot_expander_en: conf[4][3:0], msx_type: conf[4][5:4]};
                  msx_loader_pkg::CONFIG_KBD_LAYOUT:
                     ddr_adr <= ddr_adr + AW'(msx_loader_pkg::KBD_SKIP);
                  msx_loader_pkg::CONFIG_SLOT_INTERNAL: begin
                     record <= '{slot_subslot: conf[3][3:0],
                                 data_id: msx_loader_pkg::data_id_t'(conf[4]),
                                 pages: {conf[5][2:0], conf[6]},
                                 device: conf[7], mapper: conf[8],
                                 mode: conf[9], param: conf[10]};
                     state  <= S_FILL;
                  end
                  default: ;                          // Unknown type, skip
               endcase
            end
         end
         S_FILL: begin
            state <= S_STORE;
            if (record.pages != 11'd0) begin
               add_lookup <= 1'b1;
               lookup     <= '{addr: ram_adr, size: 16'(record.pages),
                               ro: record.data_id != msx_loader_pkg::DATA_RAM};
               inc_ref    <= 1'b1;
               if (record.data_id == msx_loader_pkg::DATA_ROM ||
                   record.data_id == msx_loader_pkg::DATA_RAM) begin
                  go        <= 1'b1;
                  op        <= (record.data_id == msx_loader_pkg::DATA_ROM) ?
                               msx_loader_pkg::OP_COPY : msx_loader_pkg::OP_FILL;
                  ddr_start <= ddr_adr;               // Payload follows header
                  ram_start <= ram_adr;
                  count     <= fill_bytes;
                  state     <= S_FILL_WAIT;
               end
            end
         end
         S_FILL_WAIT: begin
            if (done) begin
               if (record.data_id == msx_loader_pkg::DATA_ROM) ddr_adr <= next_ddr;
               ram_adr <= ram_adr + fill_bytes[26:0];
               state   <= S_STORE;
            end
         end
         S_STORE: begin
            apply <= 1'b1;
            state <= S_READ;
         end
         default: ;
      endcase
      if (dl_last && !ioctl_download && ioctl_index[5:0] == 6'd1) begin
         image_size <= {1'b0, ioctl_addr};
         ddr_adr    <= 28'd0;
         ram_adr    <= 27'd0;
         ref_ram    <= 4'd0;
         inc_ref    <= 1'b0;
         clean      <= 1'b1;
         state      <= S_CLEAN;
      end
      if (reset) begin
         state       <= S_IDLE;
         dl_last     <= 1'b0;
         inc_ref     <= 1'b0;
         go          <= 1'b0;
         clean       <= 1'b0;
         apply       <= 1'b0;
         add_lookup  <= 1'b0;
         bios_config <= '0;
      end
   end

endmodule

`default_nettype wire

// File: src/msx_loader_top.sv
`default_nettype none

module msx_loader_top #(
   parameter int PAGE_BITS = 14
) (
   input  wire logic                         clk,
   input  wire logic                         reset,
   input  wire logic                         ioctl_download,
   input  wire logic [15:0]                  ioctl_index,
   input  wire logic [26:0]                  ioctl_addr,
   input  wire msx_loader_pkg::wb_s_t        ddr_s,
   input  wire msx_loader_pkg::wb_s_t        ram_s,
   input  wire logic [5:0]                   slot_idx,
   input  wire logic [3:0]                   lookup_idx,
   output msx_loader_pkg::wb_ddr_m_t         ddr_m,
   output msx_loader_pkg::wb_ram_m_t         ram_m,
   output logic                              reset_rq,
   output msx_loader_pkg::bios_config_t      bios_config,
   output msx_loader_pkg::slot_entry_t       slot_entry,
   output msx_loader_pkg::lookup_t           lookup_entry
);

   logic                      go;
   msx_loader_pkg::mover_op_t op;
   logic [27:0]               ddr_start;
   logic [26:0]               ram_start;
   logic [27:0]               count;
   logic                      hdr_valid;
   logic [7:0]                hdr_byte;
   logic                      done;
   logic [27:0]               next_ddr;
   logic                      clean;
   logic                      clean_done;
   logic                      apply;
   msx_loader_pkg::record_t   record;
   logic [3:0]                ref_ram;
   logic                      add_lookup;
   msx_loader_pkg::lookup_t   lookup;

   config_sequencer #(.PAGE_BITS(PAGE_BITS)) u_seq (
      .clk            (clk),
      .reset          (reset),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .ioctl_addr     (ioctl_addr),
      .hdr_valid      (hdr_valid),
      .hdr_byte       (hdr_byte),
      .done           (done),
      .next_ddr       (next_ddr),
      .clean_done     (clean_done),
      .go             (go),
      .op             (op),
      .ddr_start      (ddr_start),
      .ram_start      (ram_start),
      .count          (count),
      .clean          (clean),
      .apply          (apply),
      .record         (record),
      .ref_ram        (ref_ram),
      .add_lookup     (add_lookup),
      .lookup         (lookup),
      .reset_rq       (reset_rq),
      .bios_config    (bios_config)
   );

   byte_mover u_mover (
      .clk       (clk),
      .reset     (reset),
      .go        (go),
      .op        (op),
      .ddr_start (ddr_start),
      .ram_start (ram_start),
      .count     (count),
      .ddr_s     (ddr_s),
      .ram_s     (ram_s),
      .hdr_valid (hdr_valid),
      .hdr_byte  (hdr_byte),
      .done      (done),
      .next_ddr  (next_ddr),
      .ddr_m     (ddr_m),
      .ram_m     (ram_m)
   );

   slot_map u_map (
      .clk          (clk),
      .reset        (reset),
      .clean        (clean),
      .apply        (apply),
      .record       (record),
      .ref_ram      (ref_ram),
      .add_lookup   (add_lookup),
      .lookup       (lookup),
      .slot_idx     (slot_idx),
      .lookup_idx   (lookup_idx),
      .clean_done   (clean_done),
      .slot_entry   (slot_entry),
      .lookup_entry (lookup_entry)
   );

endmodule

`default_nettype wire

// File: verif/tb_checks.svh
logic [31:0]                  rng_state = 32'hf588;
msx_loader_pkg::slot_entry_t  slot_exp [64];
msx_loader_pkg::lookup_t      lookup_exp [16];
msx_loader_pkg::bios_config_t bios_exp;
logic [7:0]                   ram_exp [RAM_BYTES];
int                           lookup_count;
int                           moved_bytes;
logic [27:0]                  last_read_exp;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
   logic [31:0] y;
   y = x ^ (x << 13);
   y = y ^ (y >> 17);
   y = y ^ (y << 5);
   return y;
endfunction

function automatic logic [31:0] next_random();
   rng_state = xorshift32(rng_state);
   return rng_state;
endfunction

// FF where RAM address bits 8 and 1 agree
function automatic logic [7:0] power_on_byte(input logic [26:0] a);
   return (a[8] == a[1]) ? 8'hff : 8'h00;
endfunction

// Walks the DDR3 image the way the loader should and predicts every result
task automatic model_walk();
   int                          adr;
   int                          ram_adr;
   int                          refn;
   int                          nbytes;
   int                          base;
   logic                        walking;
   logic [7:0]                  h [16];
   logic [10:0]                 pages;
   logic [1:0]                  m;
   logic [1:0]                  p;
   msx_loader_pkg::slot_entry_t old [64];
   msx_loader_pkg::slot_entry_t src;
   adr         = 0;
   ram_adr     = 0;
   refn        = 0;
   moved_bytes = 0;
   bios_exp    = '0;
   walking     = 1'b1;
   for (int i = 0; i < RAM_BYTES; i++) ram_exp[i] = ram_mem[i];
   for (int i = 0; i < 64; i++) slot_exp[i] = '0;
   while (walking && adr < image_size) begin
      for (int k = 0; k < 16; k++) h[k] = ddr_mem[10'(adr + k)];
      last_read_exp = 28'(adr + 15);
      adr += 16;
      if (h[0] != "M" || h[1] != "S" || h[2] != "X") begin
         walking = 1'b0;
      end else if (h[3][7:4] == msx_loader_pkg::CONFIG_CONFIG) begin
         bios_exp = '{slot_expander_en: h[4][3:0], msx_type: h[4][5:4]};
      end else if (h[3][7:4] == msx_loader_pkg::CONFIG_KBD_LAYOUT) begin
         adr += msx_loader_pkg::KBD_SKIP;
      end else if (h[3][7:4] == msx_loader_pkg::CONFIG_SLOT_INTERNAL) begin
         pages  = {h[5][2:0], h[6]};
         nbytes = int'(pages) << PAGE_BITS;
         base   = int'(h[3][3:0]) * 4;                // First block of the subslot
         if (pages != 11'd0) begin
            lookup_exp[4'(refn)] = '{addr: 27'(ram_adr), size: 16'(pages),
                                     ro: h[4] != msx_loader_pkg::DATA_RAM};
            if (h[4] == msx_loader_pkg::DATA_ROM) begin
               for (int k = 0; k < nbytes; k++)
                  ram_exp[10'(ram_adr + k)] = ddr_mem[10'(adr + k)];
               adr         += nbytes;
               ram_adr     += nbytes;
               moved_bytes += nbytes;
            end else if (h[4] == msx_loader_pkg::DATA_RAM) begin
               for (int k = 0; k < nbytes; k++)
                  ram_exp[10'(ram_adr + k)] = power_on_byte(27'(ram_adr + k));
               ram_adr     += nbytes;
               moved_bytes += nbytes;
            end
         end
         old = slot_exp;
         for (int b = 0; b < 4; b++) begin
            m   = h[9][2*b +: 2];
            p   = h[10][2*b +: 2];
            src = old[6'(base + int'(p))];
            case (m)
               2'd1: slot_exp[6'(base + b)] = '{mapper: src.mapper,
                  device: msx_loader_pkg::DEVICE_NONE,
                  ref_ram: src.ref_ram, offset_ram: src.offset_ram};
               2'd2: slot_exp[6'(base + b)] = '{mapper: h[8], device: h[7],
                  ref_ram: 4'(refn), offset_ram: p};
               2'd3: slot_exp[6'(base + b)] = '{mapper: msx_loader_pkg::MAPPER_UNUSED,
                  device: h[7], ref_ram: 4'(refn), offset_ram: p};
               default: ;
            endcase
         end
         if (pages != 11'd0) refn++;
      end
   end
   lookup_count = refn;
endtask

task automatic check_slot(input int idx, input msx_loader_pkg::slot_entry_t got,
                          input msx_loader_pkg::slot_entry_t exp);
   if (got !== exp)
      stop_on_error($sformatf("MISMATCH slot_entry[%0d] got %h expected %h", idx, got, exp));
endtask

task automatic check_lookup(input int idx, input msx_loader_pkg::lookup_t got,
                            input msx_loader_pkg::lookup_t exp);
   if (got !== exp)
      stop_on_error($sformatf("MISMATCH lookup_entry[%0d] got %h expected %h", idx, got, exp));
endtask

task automatic check_bios(input msx_loader_pkg::bios_config_t got,
                          input msx_loader_pkg::bios_config_t exp);
   if (got !== exp)
      stop_on_error($sformatf("MISMATCH bios_config got %h expected %h", got, exp));
endtask

task automatic check_byte(input int adr, input logic [7:0] got, input logic [7:0] exp);
   if (got !== exp)
      stop_on_error($sformatf("MISMATCH ram[%h] got %h expected %h", adr, got, exp));
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
   if (got !== exp)
      stop_on_error($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
endtask

task automatic check_addr(input string name, input logic [27:0] got, input logic [27:0] exp);
   if (got !== exp)
      stop_on_error($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
endtask

// File: verif/tb_top.sv
`default_nettype none

module tb_top;

   localparam int PAGE_BITS       = 4;
   localparam int DDR_BYTES       = 1024;
   localparam int RAM_BYTES       = 1024;
   localparam int CYCLES_PER_BYTE = 16;               // DDR3 read plus RAM write at worst wait
   localparam int SHORT_IMAGE     = 16;               // CONFIG record alone

   logic                         clk;
   logic                         reset;
   logic                         ioctl_download;
   logic [15:0]                  ioctl_index;
   logic [26:0]                  ioctl_addr;
   msx_loader_pkg::wb_s_t        ddr_s;
   msx_loader_pkg::wb_s_t        ram_s;
   logic [5:0]                   slot_idx;
   logic [3:0]                   lookup_idx;
   msx_loader_pkg::wb_ddr_m_t    ddr_m;
   msx_loader_pkg::wb_ram_m_t    ram_m;
   logic                         reset_rq;
   msx_loader_pkg::bios_config_t bios_config;
   msx_loader_pkg::slot_entry_t  slot_entry;
   msx_loader_pkg::lookup_t      lookup_entry;

   logic [7:0]  ddr_mem [DDR_BYTES];
   logic [7:0]  ram_mem [RAM_BYTES];
   int          image_size;
   int          watchdog_cycles = 0;
   logic [27:0] ddr_max_read;

   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1);
   endtask

   `include "tb_checks.svh"

   msx_loader_top #(.PAGE_BITS(PAGE_BITS)) u_dut (
      .clk            (clk),
      .reset          (reset),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .ioctl_addr     (ioctl_addr),
      .ddr_s          (ddr_s),
      .ram_s          (ram_s),
      .slot_idx       (slot_idx),
      .lookup_idx     (lookup_idx),
      .ddr_m          (ddr_m),
      .ram_m          (ram_m),
      .reset_rq       (reset_rq),
      .bios_config    (bios_config),
      .slot_entry     (slot_entry),
      .lookup_entry   (lookup_entry)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic put_header(input int base, input logic [7:0] typ_slot, input logic [7:0] id,
                             input logic [7:0] pg_hi, input logic [7:0] pg_lo,
                             input logic [7:0] device, input logic [7:0] mapper,
                             input logic [7:0] mode, input logic [7:0] param);
      ddr_mem[10'(base)]      = "M";
      ddr_mem[10'(base + 1)]  = "S";
      ddr_mem[10'(base + 2)]  = "X";
      ddr_mem[10'(base + 3)]  = typ_slot;
      ddr_mem[10'(base + 4)]  = id;
      ddr_mem[10'(base + 5)]  = pg_hi;
      ddr_mem[10'(base + 6)]  = pg_lo;
      ddr_mem[10'(base + 7)]  = device;
      ddr_mem[10'(base + 8)]  = mapper;
      ddr_mem[10'(base + 9)]  = mode;
      ddr_mem[10'(base + 10)] = param;
      for (int k = 11; k < 16; k++) ddr_mem[10'(base + k)] = 8'h00;
   endtask

   task automatic build_image();
      logic [31:0] r;
      for (int i = 0; i < DDR_BYTES; i++) begin
         r          = next_random();
         ddr_mem[i] = r[7:0];                         // Payload and keyboard data stay random
      end
      for (int i = 0; i < RAM_BYTES; i++) ram_mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5a;
      put_header(0,   8'h00, 8'h2b, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00);
      put_header(16,  8'h10, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00);
      put_header(544, 8'h25, 8'h01, 8'hf8, 8'h02, 8'h11, 8'h22, 8'h3a, 8'he4);  // ROM with 2 pages
      put_header(592, 8'h2a, 8'h02, 8'h00, 8'h01, 8'h33, 8'h44, 8'haa, 8'h1b);  // RAM with 1 page
      put_header(608, 8'h25, 8'h00, 8'h00, 8'h01, 8'h55, 8'h66, 8'h94, 8'h90);  // Mode 1 copies
      put_header(624, 8'h00, 8'h3f, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00);
      ddr_mem[626] = "Y";                             // Broken signature
      for (int k = 640; k < 656; k++) ddr_mem[k] = 8'h00;
      image_size = 656;
   endtask

   // Pulses a download with index 1 and waits for the walk to end
   task automatic run_download(input int size);
      ddr_max_read = '0;
      @(posedge clk);
      #1;
      ioctl_index    = 16'd1;
      ioctl_download = 1'b1;
      repeat (4) @(posedge clk);
      #1 ioctl_addr = 27'(size);
      @(posedge clk);
      #1 ioctl_download = 1'b0;
      @(posedge clk);
      #1 check_flag("reset_rq", reset_rq, 1'b1);      // One cycle after the falling edge
      do begin
         @(posedge clk);
         #1;
      end while (reset_rq);
      check_flag("ddr_m.cyc", ddr_m.cyc, 1'b0);
      check_flag("ram_m.cyc", ram_m.cyc, 1'b0);
   endtask

   task automatic compare_results();
      check_bios(bios_config, bios_exp);
      check_addr("last DDR3 read address", ddr_max_read, last_read_exp);
      for (int i = 0; i < 64; i++) begin
         @(posedge clk);
         #1 slot_idx = 6'(i);
         #10 check_slot(i, slot_entry, slot_exp[i]);
      end
      for (int i = 0; i < lookup_count; i++) begin
         @(posedge clk);
         #1 lookup_idx = 4'(i);
         #10 check_lookup(i, lookup_entry, lookup_exp[i]);
      end
      for (int i = 0; i < RAM_BYTES; i++) check_byte(i, ram_mem[i], ram_exp[i]);
   endtask

   // DDR3 and RAM slaves ack after 0 to 3 random wait cycles
   initial begin : bus_models
      int   ddr_wait;
      int   ram_wait;
      logic ddr_busy;
      logic ram_busy;
      ddr_s    = '0;
      ram_s    = '0;
      ddr_wait = 0;
      ram_wait = 0;
      ddr_busy = 1'b0;
      ram_busy = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         if (ddr_s.ack) begin
            ddr_s.ack = 1'b0;
            ddr_busy  = 1'b0;
         end else if (ddr_m.cyc && ddr_m.stb) begin
            if (!ddr_busy) begin
               ddr_busy = 1'b1;
               ddr_wait = int'(next_random() & 32'd3);
            end
            if (ddr_wait == 0) begin
               if (ddr_m.we)
                  stop_on_error("Write cycle seen on the DDR3 bus");
               if (int'(ddr_m.adr) >= DDR_BYTES)
                  stop_on_error("DDR3 read outside the image memory");
               ddr_s.dat = ddr_mem[ddr_m.adr[9:0]];
               if (ddr_m.adr > ddr_max_read) ddr_max_read = ddr_m.adr;
               ddr_s.ack = 1'b1;
            end else begin
               ddr_wait--;
            end
         end
         if (ram_s.ack) begin
            ram_s.ack = 1'b0;
            ram_busy  = 1'b0;
         end else if (ram_m.cyc && ram_m.stb) begin
            if (!ram_busy) begin
               ram_busy = 1'b1;
               ram_wait = int'(next_random() & 32'd3);
            end
            if (ram_wait == 0) begin
               if (!ram_m.we)
                  stop_on_error("Read cycle seen on the RAM bus");
               if (int'(ram_m.adr) >= RAM_BYTES)
                  stop_on_error("RAM write outside the modeled memory");
               ram_mem[ram_m.adr[9:0]] = ram_m.dat;
               ram_s.ack = 1'b1;
            end else begin
               ram_wait--;
            end
         end
      end
   end

   initial begin : watchdog
      wait (watchdog_cycles > 0);
      repeat (watchdog_cycles) @(posedge clk);
      stop_on_error($sformatf("Timeout, loader still busy after %0d cycles", watchdog_cycles));
   end

   initial begin : stimulus
      reset          = 1'b1;
      ioctl_download = 1'b0;
      ioctl_index    = 16'd0;
      ioctl_addr     = 27'd0;
      slot_idx       = 6'd0;
      lookup_idx     = 4'd0;
      ddr_max_read   = '0;
      build_image();
      model_walk();
      watchdog_cycles = 2 * 1100 +
                        (image_size + SHORT_IMAGE + moved_bytes) * CYCLES_PER_BYTE;
      repeat (5) @(posedge clk);
      #1 reset = 1'b0;
      check_flag("reset_rq", reset_rq, 1'b0);
      check_flag("ddr_m.cyc", ddr_m.cyc, 1'b0);
      check_flag("ram_m.cyc", ram_m.cyc, 1'b0);

      run_download(image_size);
      compare_results();

      // Short image ends on its size and leaves every block clean
      ddr_mem[4] = 8'h1c;
      image_size = SHORT_IMAGE;
      model_walk();
      run_download(image_size);
      compare_results();

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// File: sources.f
+incdir+verif
src/msx_loader_pkg.sv
src/wb_master.sv
src/byte_mover.sv
src/slot_map.sv
src/config_sequencer.sv
src/msx_loader_top.sv
verif/tb_top.sv

// File: run.sh
#!/bin/sh
# Build and run the loader testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f sources.f --top-module tb_top -o tb_top
./obj_dir/tb_top
